/* common/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// RV32I fixes all of these

// data word and byte address width
`define LSU_XLEN 32

// one enable per byte lane of a word
`define LSU_MBE_W 4

// x0..x31
`define LSU_RD_W 5

`endif

/* common/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

    // load/store operations seen by the unit
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } lsu_op_e;

    // request from the issue side
    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_RD_W-1:0]   rd;
        logic [`LSU_XLEN-1:0]   base;       // rs1 value
        logic [`LSU_XLEN-1:0]   offset;     // sign-extended immediate
        logic [`LSU_XLEN-1:0]   store_data; // rs2 value, low bits used
    } lsu_req_t;

    // EX/MEM register contents
    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_RD_W-1:0]   rd;
        logic [`LSU_XLEN-1:0]   addr;       // word aligned
        logic [`LSU_MBE_W-1:0]  mask;
        logic [`LSU_XLEN-1:0]   wdata;      // already in its byte lanes
    } ex_mem_t;

    // MEM/WB register contents, loads only
    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_RD_W-1:0]   rd;
        logic [`LSU_MBE_W-1:0]  mask;
        logic [`LSU_XLEN-1:0]   mdr;        // raw word from the cache
    } mem_wb_t;

    // writeback to the register file
    typedef struct packed {
        logic [`LSU_RD_W-1:0]   rd;
        logic [`LSU_XLEN-1:0]   value;
    } wb_t;

endpackage : lsu_pkg

/* verilog/mem_op_gen.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_op_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    input  logic              stall,
    output logic              ex_mem_valid,
    output lsu_pkg::ex_mem_t  ex_mem
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0]  eff_addr;
    logic [`LSU_MBE_W-1:0] mask;
    logic [`LSU_XLEN-1:0]  lane_data;
    logic                  is_store;
    ex_mem_t               ex_mem_next;

    assign eff_addr = req.base + req.offset;  // base + offset
    assign is_store = req.op inside {op_sb, op_sh, op_sw};

    // byte enables from access size and low address bits
    // misaligned halves and words are not handled
    always_comb begin : mask_gen
        case (req.op)
            op_lb, op_lbu, op_sb: mask = 4'b0001 << eff_addr[1:0];
            op_lh, op_lhu, op_sh: mask = eff_addr[1] ? 4'b1100 : 4'b0011;
            default:              mask = 4'b1111;  // lw, sw
        endcase
    end

    // shift store data into the enabled lanes
    always_comb begin : store_align
        lane_data = '0;
        if (is_store) begin
            case (mask)
                4'b0001: lane_data = {24'b0, req.store_data[7:0]};
                4'b0010: lane_data = {16'b0, req.store_data[7:0], 8'b0};
                4'b0100: lane_data = {8'b0, req.store_data[7:0], 16'b0};
                4'b1000: lane_data = {req.store_data[7:0], 24'b0};
                4'b0011: lane_data = {16'b0, req.store_data[15:0]};
                4'b1100: lane_data = {req.store_data[15:0], 16'b0};
                4'b1111: lane_data = req.store_data;
                default: lane_data = '0;
            endcase
        end
    end

    always_comb begin
        ex_mem_next.op    = req.op;
        ex_mem_next.rd    = req.rd;
        ex_mem_next.addr  = {eff_addr[`LSU_XLEN-1:2], 2'b00};  // word aligned
        ex_mem_next.mask  = mask;
        ex_mem_next.wdata = lane_data;
    end

    // EX/MEM register, held while the memory stage waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_valid <= 1'b0;
        end else if (!stall) begin
            ex_mem_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && req_valid) begin
            ex_mem <= ex_mem_next;
        end
    end

endmodule : mem_op_gen

/* verilog/mem_access.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_access (
    input  logic                  clk,
    input  logic                  rst_n,

    // from EX/MEM
    input  logic                  ex_mem_valid,
    input  lsu_pkg::ex_mem_t      ex_mem,

    // data cache
    input  logic [`LSU_XLEN-1:0]  data_mem_rdata,
    input  logic                  data_mem_resp,
    output logic                  stall,
    output logic                  data_read,
    output logic                  data_write,
    output logic [`LSU_XLEN-1:0]  data_mem_address,
    output logic [`LSU_MBE_W-1:0] data_mbe,
    output logic [`LSU_XLEN-1:0]  data_mem_wdata,

    // to MEM/WB
    output logic                  mem_wb_valid,
    output lsu_pkg::mem_wb_t      mem_wb
);
    import lsu_pkg::*;

    logic    is_load;
    logic    is_store;
    logic    load_done;
    mem_wb_t mem_wb_next;

    assign is_load  = ex_mem.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    assign is_store = ex_mem.op inside {op_sb, op_sh, op_sw};

    // strobes stay up until the cache answers
    assign data_read  = ex_mem_valid & is_load;
    assign data_write = ex_mem_valid & is_store;

    assign data_mem_address = ex_mem_valid ? ex_mem.addr : '0;
    assign data_mbe         = ex_mem_valid ? ex_mem.mask : '0;
    assign data_mem_wdata   = data_write ? ex_mem.wdata : '0;  // zero on reads

    // request held and no answer yet, upstream must wait
    // a response frees the stage so the next request loads this edge
    assign stall = ex_mem_valid & ~data_mem_resp;

    assign load_done = data_read & data_mem_resp;

    always_comb begin
        mem_wb_next.op   = ex_mem.op;
        mem_wb_next.rd   = ex_mem.rd;
        mem_wb_next.mask = ex_mem.mask;
        mem_wb_next.mdr  = data_mem_rdata;  // valid only in the resp cycle
    end

    // stores end here, only loads go on to writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_valid <= 1'b0;
        end else begin
            mem_wb_valid <= load_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_done) begin
            mem_wb <= mem_wb_next;
        end
    end

endmodule : mem_access

/* verilog/load_writeback.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module load_writeback (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mem_wb_valid,
    input  lsu_pkg::mem_wb_t mem_wb,
    output logic             wb_valid,
    output lsu_pkg::wb_t     wb
);
    import lsu_pkg::*;

    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    logic [`LSU_XLEN-1:0] load_value;

    // pick the lane named by the mask
    always_comb begin : lane_sel
        case (mem_wb.mask)
            4'b0010: byte_lane = mem_wb.mdr[15:8];
            4'b0100: byte_lane = mem_wb.mdr[23:16];
            4'b1000: byte_lane = mem_wb.mdr[31:24];
            default: byte_lane = mem_wb.mdr[7:0];  // 0001
        endcase
        half_lane = mem_wb.mask[2] ? mem_wb.mdr[31:16] : mem_wb.mdr[15:0];
    end

    // sign or zero extend per load type
    always_comb begin : extend
        case (mem_wb.op)
            op_lb:   load_value = {{24{byte_lane[7]}}, byte_lane};
            op_lbu:  load_value = {24'b0, byte_lane};
            op_lh:   load_value = {{16{half_lane[15]}}, half_lane};
            op_lhu:  load_value = {16'b0, half_lane};
            default: load_value = mem_wb.mdr;  // lw
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_wb_valid;  // one pulse per load
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_valid) begin
            wb.rd    <= mem_wb.rd;
            wb.value <= load_value;
        end
    end

endmodule : load_writeback

/* verilog/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // request side
    input  logic                  req_valid,
    input  lsu_pkg::lsu_req_t     req,
    output logic                  stall,

    // data cache port
    output logic                  data_read,
    output logic                  data_write,
    output logic [`LSU_XLEN-1:0]  data_mem_address,
    output logic [`LSU_MBE_W-1:0] data_mbe,
    output logic [`LSU_XLEN-1:0]  data_mem_wdata,
    input  logic [`LSU_XLEN-1:0]  data_mem_rdata,
    input  logic                  data_mem_resp,

    // writeback
    output logic                  wb_valid,
    output lsu_pkg::wb_t          wb
);
    import lsu_pkg::*;

    logic    ex_mem_valid;
    ex_mem_t ex_mem;
    logic    mem_wb_valid;
    mem_wb_t mem_wb;

    mem_op_gen u_mem_op_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .stall        (stall),            // freezes EX/MEM while cache busy
        .ex_mem_valid (ex_mem_valid),
        .ex_mem       (ex_mem)
    );

    mem_access u_mem_access (
        .clk              (clk),
        .rst_n            (rst_n),
        .ex_mem_valid     (ex_mem_valid),
        .ex_mem           (ex_mem),
        .data_mem_rdata   (data_mem_rdata),
        .data_mem_resp    (data_mem_resp),
        .stall            (stall),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_mem_address (data_mem_address),
        .data_mbe         (data_mbe),
        .data_mem_wdata   (data_mem_wdata),
        .mem_wb_valid     (mem_wb_valid),
        .mem_wb           (mem_wb)
    );

    load_writeback u_load_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb),
        .wb_valid     (wb_valid),
        .wb           (wb)
    );

endmodule : lsu_top

/* test/tb_mem_model.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  data_read,
    input  logic                  data_write,
    input  logic [`LSU_XLEN-1:0]  data_mem_address,
    input  logic [`LSU_MBE_W-1:0] data_mbe,
    input  logic [`LSU_XLEN-1:0]  data_mem_wdata,
    output logic [`LSU_XLEN-1:0]  data_mem_rdata,
    output logic                  data_mem_resp
);
    logic [7:0]  mem [256];     // 256 bytes, address bits above 7 ignored
    logic [31:0] lfsr;
    logic [1:0]  wait_left;     // extra cycles before the answer
    logic        busy;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    // every byte differs, odd multiplier covers all addresses
    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[8'(a)] = 8'(a * 37) ^ 8'h5c;
        end
    end

    always @(posedge clk or negedge rst_n) begin : respond
        logic [7:0] word_base;
        if (!rst_n) begin
            data_mem_resp  <= 1'b0;
            data_mem_rdata <= '0;
            busy = 1'b0;
            wait_left = 2'd0;
            lfsr = 32'h1fdff84e;
        end else begin
            data_mem_resp <= 1'b0;
            if ((data_read || data_write) && !data_mem_resp) begin
                if (!busy) begin
                    lfsr = lfsr_step(lfsr);  // two bits, one to four cycles
                    wait_left[0] = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                    wait_left[1] = lfsr[0];
                    busy = 1'b1;
                end
                if (wait_left == 2'd0) begin
                    word_base = {data_mem_address[7:2], 2'b00};
                    for (int i = 0; i < 4; i++) begin
                        if (data_write && data_mbe[i]) begin
                            mem[word_base + 8'(i)] = data_mem_wdata[8*i +: 8];
                        end
                        data_mem_rdata[8*i +: 8] <= mem[word_base + 8'(i)];
                    end
                    data_mem_resp <= 1'b1;
                    busy = 1'b0;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

endmodule : tb_mem_model

/* test/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int NUM_REQ = 300;
    localparam int RST_CYC = 16;
    localparam int MAX_CYC = NUM_REQ * 8 + RST_CYC;

    typedef struct packed {
        logic                  is_store;
        logic [`LSU_XLEN-1:0]  addr;
        logic [`LSU_MBE_W-1:0] mask;
        logic [`LSU_XLEN-1:0]  wdata;
    } port_exp_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req_valid;
    lsu_req_t              req;
    logic                  stall;
    logic                  data_read;
    logic                  data_write;
    logic [`LSU_XLEN-1:0]  data_mem_address;
    logic [`LSU_MBE_W-1:0] data_mbe;
    logic [`LSU_XLEN-1:0]  data_mem_wdata;
    logic [`LSU_XLEN-1:0]  data_mem_rdata;
    logic                  data_mem_resp;
    logic                  wb_valid;
    wb_t                   wb;

    logic [7:0]  ref_mem [256];
    port_exp_t   port_q [$];        // cache accesses not yet answered
    wb_t         wb_q [$];          // loads not yet written back
    port_exp_t   exp_port;
    wb_t         exp_wb;
    int          exp_pending = 0;
    int          errors = 0;
    int          cycles = 0;
    int          issued = 0;
    int          loads_issued = 0;
    int          wb_seen = 0;
    logic [31:0] lfsr = 32'h1fdff84e;
    logic        req_started = 1'b0;
    logic        prev_stall = 1'b0;
    logic [31:0] prev_addr;
    logic [3:0]  prev_mbe;
    logic [31:0] prev_wdata;

    lsu_top u_dut (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req), .stall(stall),
        .data_read(data_read), .data_write(data_write),
        .data_mem_address(data_mem_address), .data_mbe(data_mbe),
        .data_mem_wdata(data_mem_wdata), .data_mem_rdata(data_mem_rdata),
        .data_mem_resp(data_mem_resp), .wb_valid(wb_valid), .wb(wb)
    );

    tb_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .data_read(data_read), .data_write(data_write),
        .data_mem_address(data_mem_address), .data_mbe(data_mbe),
        .data_mem_wdata(data_mem_wdata), .data_mem_rdata(data_mem_rdata),
        .data_mem_resp(data_mem_resp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("Timeout after %0d cycles, %0d requests issued", cycles, issued);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    function automatic int op_size(input lsu_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic logic [7:0] align(input lsu_op_e op, input logic [7:0] a);
        return a & ~8'(op_size(op) - 1);
    endfunction

    // random rd and offset with base picked so that base + offset hits the byte
    task automatic issue(input lsu_op_e op, input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd_bits;
        logic [31:0] off;
        draw(5, rd_bits);
        draw(12, off);
        off = {{20{off[11]}}, off[11:2], 2'b00};
        req.op         <= op;
        req.rd         <= rd_bits[4:0];
        req.offset     <= off;
        req.base       <= (32'h0000_8000 | 32'(addr)) - off;
        req.store_data <= data;
        req_valid      <= 1'b1;
        req_started    <= 1'b1;
        issued++;
        do @(posedge clk); while (stall);
        req_valid <= 1'b0;
    endtask

    // reference model updated in request order at acceptance
    always @(posedge clk) begin : track
        logic [7:0]  a;
        int          n;
        logic [31:0] v;
        port_exp_t   pe;
        wb_t         we;
        if (rst_n) begin
            if ((data_read || data_write) && data_mem_resp) begin
                void'(port_q.pop_front());
            end
            if (wb_valid) begin
                wb_seen++;
                if (wb_q.size() > 0) begin
                    void'(wb_q.pop_front());
                end
            end
            if (req_valid && !stall) begin
                a = 8'(req.base + req.offset);
                n = op_size(req.op);
                pe.is_store = req.op inside {op_sb, op_sh, op_sw};
                pe.addr = (req.base + req.offset) & ~32'h3;
                pe.mask = 4'((1 << n) - 1) << a[1:0];
                pe.wdata = '0;
                v = '0;
                for (int i = 0; i < n; i++) begin
                    if (pe.is_store) begin
                        pe.wdata[8*(a[1:0] + i) +: 8] = req.store_data[8*i +: 8];
                        ref_mem[a + 8'(i)] = req.store_data[8*i +: 8];
                    end
                end
                for (int i = n - 1; i >= 0; i--) begin
                    v = {v[23:0], ref_mem[a + 8'(i)]};  // little endian
                end
                if (req.op == op_lb) v = {{24{v[7]}}, v[7:0]};
                if (req.op == op_lh) v = {{16{v[15]}}, v[15:0]};
                if (!pe.is_store) begin
                    we.rd = req.rd;
                    we.value = v;
                    wb_q.push_back(we);
                    loads_issued++;
                end
                port_q.push_back(pe);
            end
        end
        exp_port    <= (port_q.size() > 0) ? port_q[0] : '0;
        exp_wb      <= (wb_q.size() > 0) ? wb_q[0] : '0;
        exp_pending <= wb_q.size();
    end

    always @(posedge clk) begin
        prev_stall <= rst_n && stall;
        prev_addr  <= data_mem_address;
        prev_mbe   <= data_mbe;
        prev_wdata <= data_mem_wdata;
    end

    reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !req_started |-> !(stall || data_read || data_write || wb_valid) && data_mbe == '0)
        else begin
            errors++;
            $display("Error at %0t: after reset stall=%b data_read=%b data_write=%b",
                     $time, $sampled(stall), $sampled(data_read), $sampled(data_write));
            $display("  data_mbe=%h wb_valid=%b, expected all zero",
                     $sampled(data_mbe), $sampled(wb_valid));
        end

    stall_rule: assert property (@(posedge clk) disable iff (!rst_n)
        stall == ((data_read || data_write) && !data_mem_resp))
        else begin
            errors++;
            $display("Error at %0t: stall is %b, expected %b", $time, $sampled(stall),
                     $sampled((data_read || data_write) && !data_mem_resp));
        end

    port_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) |-> data_mem_address == exp_port.addr)
        else begin
            errors++;
            $display("Error at %0t: data_mem_address is %h, expected %h", $time,
                     $sampled(data_mem_address), $sampled(exp_port.addr));
        end

    port_mbe: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) |-> data_mbe == exp_port.mask)
        else begin
            errors++;
            $display("Error at %0t: data_mbe is %h, expected %h", $time,
                     $sampled(data_mbe), $sampled(exp_port.mask));
        end

    port_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        data_write |-> data_mem_wdata == exp_port.wdata)
        else begin
            errors++;
            $display("Error at %0t: data_mem_wdata is %h, expected %h", $time,
                     $sampled(data_mem_wdata), $sampled(exp_port.wdata));
        end

    port_kind: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) |-> data_write == exp_port.is_store
                                      && data_read == !exp_port.is_store)
        else begin
            errors++;
            $display("Error at %0t: data_read is %b, data_write is %b, expected %b and %b",
                     $time, $sampled(data_read), $sampled(data_write),
                     $sampled(!exp_port.is_store), $sampled(exp_port.is_store));
        end

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        prev_stall |-> data_mem_address == prev_addr && data_mbe == prev_mbe
                       && data_mem_wdata == prev_wdata)
        else begin
            errors++;
            $display("Error at %0t: cache port moved under stall, address %h was %h,",
                     $time, $sampled(data_mem_address), $sampled(prev_addr));
            $display("  data_mbe %h was %h, data_mem_wdata %h was %h", $sampled(data_mbe),
                     $sampled(prev_mbe), $sampled(data_mem_wdata), $sampled(prev_wdata));
        end

    wb_expected: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> exp_pending > 0)
        else begin
            errors++;
            $display("Writeback at %0t arrived with no load outstanding", $time);
        end

    wb_rd_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb.rd == exp_wb.rd)
        else begin
            errors++;
            $display("Error at %0t: wb.rd is %0d, expected %0d", $time,
                     $sampled(wb.rd), $sampled(exp_wb.rd));
        end

    wb_value_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb.value == exp_wb.value)
        else begin
            errors++;
            $display("Error at %0t: wb.value is %h, expected %h", $time,
                     $sampled(wb.value), $sampled(exp_wb.value));
        end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] d;
        lsu_op_e     op;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
        for (int a = 0; a < 256; a++) begin
            ref_mem[8'(a)] = u_mem.mem[8'(a)];  // same preload as the memory
        end
        repeat (2) @(posedge clk);

        // two random-width stores per word and a read-back of each word
        for (int w = 0; w < 16; w++) begin
            for (int k = 0; k < 2; k++) begin
                draw(4, r);
                draw(32, d);
                op = (r[1:0] == 2'd0) ? op_sb : (r[1:0] == 2'd1) ? op_sh : op_sw;
                issue(op, align(op, {6'(w), r[3:2]}), d);
            end
        end
        for (int w = 0; w < 16; w++) begin
            issue(op_lw, {6'(w), 2'b00}, '0);
        end

        // narrow loads at every legal offset over stored and preloaded words
        for (int w = 12; w < 20; w++) begin
            for (int b = 0; b < 4; b++) begin
                issue(op_lb, 8'(4 * w + b), '0);
                issue(op_lbu, 8'(4 * w + b), '0);
                if ((b % 2) == 0) begin
                    issue(op_lh, 8'(4 * w + b), '0);
                    issue(op_lhu, 8'(4 * w + b), '0);
                end
            end
        end

        // random mix over the whole memory
        for (int k = 0; k < 150; k++) begin
            draw(11, r);
            draw(32, d);
            op = lsu_op_e'(r[2:0]);
            issue(op, align(op, r[10:3]), d);
        end

        while (port_q.size() != 0 || wb_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        count_check: assert (wb_seen == loads_issued) else begin
            errors++;
            $display("Error at %0t: wb_valid count is %0d, expected %0d",
                     $time, wb_seen, loads_issued);
        end
        $display("%0d requests, %0d loads, %0d writebacks, %0d errors",
                 issued, loads_issued, wb_seen, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : lsu_tb

/* vlog.f */
+incdir+common
common/lsu_pkg.sv
verilog/mem_op_gen.sv
verilog/mem_access.sv
verilog/load_writeback.sv
verilog/lsu_top.sv
test/tb_mem_model.sv
test/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LSU testbench with Verilator, run it, and check the log.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timescale 1ns/1ps \
    -f vlog.f --top-module lsu_tb \
    -Mdir "$OBJ" -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/lsu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
